// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Data and address width of the hart
    parameter int XLEN = 32;

    // Register file address width
    parameter int REG_AW = 5;

    // Byte lanes in one data word
    parameter int NUM_LANES = 4;

    // Lane sizes in bits
    parameter int LANE_W = 8;
    parameter int HALF_W = 16;

    // Bits of address that pick a lane inside a word
    parameter int OFFS_W = $clog2(NUM_LANES);

    typedef logic [XLEN-1:0]      xword_t;
    typedef logic [REG_AW-1:0]    reg_addr_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [OFFS_W-1:0]    lane_off_t;
    typedef logic [2:0]           funct3_t;

    ////////////////////
    // Load/store funct3
    ////////////////////

    // Signed widths, shared by loads and stores
    parameter funct3_t F3_BYTE   = 3'b000;
    parameter funct3_t F3_HALF   = 3'b001;
    parameter funct3_t F3_WORD   = 3'b010;

    // Unsigned widths, loads only
    parameter funct3_t F3_BYTE_U = 3'b100;
    parameter funct3_t F3_HALF_U = 3'b101;

endpackage

`default_nettype wire

// File: lsu_bus_pkg.sv
`default_nettype none

package lsu_bus_pkg;

    // Load/store request from the execute side
    // At most one of is_load and is_store may be set
    typedef struct packed {
        logic                  valid;
        logic                  is_load;
        logic                  is_store;
        rv_isa_pkg::funct3_t   funct3;
        rv_isa_pkg::xword_t    addr;
        rv_isa_pkg::xword_t    wdata;
        rv_isa_pkg::reg_addr_t rd;
    } mem_req_t;

    // Data memory port, word aligned with byte mask
    typedef struct packed {
        rv_isa_pkg::xword_t     addr;
        logic                   ren;
        logic                   wen;
        rv_isa_pkg::lane_mask_t mask;
        rv_isa_pkg::xword_t     wdata;
    } dmem_req_t;

    // Context of one access while its read is in flight
    // Carries the dmem transaction along for the retire record
    typedef struct packed {
        logic                  valid;
        logic                  is_load;
        rv_isa_pkg::funct3_t   funct3;
        rv_isa_pkg::lane_off_t offset;
        rv_isa_pkg::reg_addr_t rd;
        dmem_req_t             dmem;
    } mem_ctx_t;

    // Retire record seen by the testbench
    // Mirrors the dmem transaction, delayed to writeback
    typedef struct packed {
        logic                   valid;
        rv_isa_pkg::reg_addr_t  rd_waddr;
        rv_isa_pkg::xword_t     rd_wdata;
        rv_isa_pkg::xword_t     dmem_addr;
        rv_isa_pkg::lane_mask_t dmem_mask;
        logic                   dmem_ren;
        logic                   dmem_wen;
        rv_isa_pkg::xword_t     dmem_rdata;
        rv_isa_pkg::xword_t     dmem_wdata;
    } retire_rec_t;

endpackage

`default_nettype wire

// File: mem_req_stage.sv
`default_nettype none

module mem_req_stage (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  lsu_bus_pkg::mem_req_t  i_req,
    output lsu_bus_pkg::dmem_req_t o_dmem,
    output lsu_bus_pkg::mem_ctx_t  o_ctx
);

    ////////////////////
    // EX/MEM register
    ////////////////////

    // Control bits cleared by reset
    logic vld_q;
    logic ld_q;
    logic st_q;

    // Payload of the access
    rv_isa_pkg::funct3_t   f3_q;
    rv_isa_pkg::xword_t    addr_q;
    rv_isa_pkg::xword_t    wdata_q;
    rv_isa_pkg::reg_addr_t rd_q;

    // Lane placement results
    rv_isa_pkg::lane_off_t  off;
    rv_isa_pkg::lane_mask_t mask;
    rv_isa_pkg::xword_t     wdata_lane;
    lsu_bus_pkg::dmem_req_t dmem;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_q <= 1'b0;
            ld_q  <= 1'b0;
            st_q  <= 1'b0;
        end else begin
            vld_q <= i_req.valid;
            ld_q  <= i_req.is_load;
            st_q  <= i_req.is_store;
        end
    end

    always_ff @(posedge i_clk) begin
        f3_q    <= i_req.funct3;
        addr_q  <= i_req.addr;
        wdata_q <= i_req.wdata;
        rd_q    <= i_req.rd;
    end

    ////////////////////
    // Lane placement
    ////////////////////

    // Byte offset inside the word
    assign off = addr_q[rv_isa_pkg::OFFS_W-1:0];

    always_comb begin
        case (f3_q)
            rv_isa_pkg::F3_BYTE, rv_isa_pkg::F3_BYTE_U: begin
                // One lane at the offset
                mask       = rv_isa_pkg::lane_mask_t'(1) << off;
                wdata_lane = wdata_q << (rv_isa_pkg::LANE_W * off);
            end
            rv_isa_pkg::F3_HALF, rv_isa_pkg::F3_HALF_U: begin
                // Only bit 1 picks the half
                mask       = off[1] ? 4'b1100 : 4'b0011;
                wdata_lane = wdata_q << (rv_isa_pkg::HALF_W * off[1]);
            end
            default: begin
                // Full word
                mask       = '1;
                wdata_lane = wdata_q;
            end
        endcase
    end

    always_comb begin
        // Word aligned address with the low lane bits cleared
        dmem.addr  = addr_q & ~rv_isa_pkg::xword_t'(rv_isa_pkg::NUM_LANES - 1);
        dmem.ren   = vld_q & ld_q;
        dmem.wen   = vld_q & st_q;
        dmem.mask  = mask;
        dmem.wdata = wdata_lane;
    end

    assign o_dmem = dmem;

    // Context follows the access down the pipe
    always_comb begin
        o_ctx.valid   = vld_q;
        o_ctx.is_load = ld_q;
        o_ctx.funct3  = f3_q;
        o_ctx.offset  = off;
        o_ctx.rd      = rd_q;
        o_ctx.dmem    = dmem;
    end

    // Illegal request with both load and store set
    a_rw_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(dmem.ren && dmem.wen))
        else $error("dmem ren and wen high together");

    // Any access touches at least one lane
    a_mask_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (dmem.ren || dmem.wen) |-> (dmem.mask != '0))
        else $error("dmem access with empty mask");

endmodule

`default_nettype wire

// File: mem_wb_stage.sv
`default_nettype none

module mem_wb_stage (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  lsu_bus_pkg::mem_ctx_t i_ctx,
    output lsu_bus_pkg::mem_ctx_t o_ctx
);

    // Control bits of the access whose read is completing
    logic vld_q;
    logic ren_q;
    logic wen_q;

    // Rest of the context, lines up with i_dmem_rdata
    lsu_bus_pkg::mem_ctx_t ctx_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_q <= 1'b0;
            ren_q <= 1'b0;
            wen_q <= 1'b0;
        end else begin
            vld_q <= i_ctx.valid;
            ren_q <= i_ctx.dmem.ren;
            wen_q <= i_ctx.dmem.wen;
        end
    end

    always_ff @(posedge i_clk) begin
        ctx_q <= i_ctx;
    end

    // Control bits from the reset flops
    always_comb begin
        o_ctx          = ctx_q;
        o_ctx.valid    = vld_q;
        o_ctx.dmem.ren = ren_q;
        o_ctx.dmem.wen = wen_q;
    end

    // Load and store never share a slot in the MEM/WB register
    a_ctx_one_op: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        vld_q |-> !(ren_q && wen_q))
        else $error("valid context with both dmem enables");

endmodule

`default_nettype wire

// File: load_align.sv
`default_nettype none

module load_align (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  lsu_bus_pkg::mem_ctx_t    i_ctx,
    input  rv_isa_pkg::xword_t       i_dmem_rdata,
    output lsu_bus_pkg::retire_rec_t o_retire
);

    ////////////////////
    // Lane extraction
    ////////////////////

    logic [rv_isa_pkg::LANE_W-1:0] byte_sel;
    logic [rv_isa_pkg::HALF_W-1:0] half_sel;
    rv_isa_pkg::xword_t            load_val;

    // Retire record, next and registered
    lsu_bus_pkg::retire_rec_t ret_d;
    lsu_bus_pkg::retire_rec_t ret_q;

    // Control bits of the record
    logic vld_q;
    logic ren_q;
    logic wen_q;

    // Byte at the offset
    assign byte_sel = i_dmem_rdata[rv_isa_pkg::LANE_W * i_ctx.offset +: rv_isa_pkg::LANE_W];

    // Half picked by offset bit 1 only
    assign half_sel = i_dmem_rdata[rv_isa_pkg::HALF_W * i_ctx.offset[1] +: rv_isa_pkg::HALF_W];

    always_comb begin
        case (i_ctx.funct3)
            rv_isa_pkg::F3_BYTE:
                load_val = {{(rv_isa_pkg::XLEN - rv_isa_pkg::LANE_W){byte_sel[7]}}, byte_sel};
            rv_isa_pkg::F3_BYTE_U:
                load_val = {{(rv_isa_pkg::XLEN - rv_isa_pkg::LANE_W){1'b0}}, byte_sel};
            rv_isa_pkg::F3_HALF:
                load_val = {{(rv_isa_pkg::XLEN - rv_isa_pkg::HALF_W){half_sel[15]}}, half_sel};
            rv_isa_pkg::F3_HALF_U:
                load_val = {{(rv_isa_pkg::XLEN - rv_isa_pkg::HALF_W){1'b0}}, half_sel};
            // LW and anything else, raw word
            default:
                load_val = i_dmem_rdata;
        endcase
    end

    ////////////////////
    // Retire register
    ////////////////////

    always_comb begin
        ret_d.valid      = i_ctx.valid;
        // Only loads write rd here
        ret_d.rd_waddr   = (i_ctx.valid && i_ctx.is_load) ? i_ctx.rd : '0;
        ret_d.rd_wdata   = load_val;
        ret_d.dmem_addr  = i_ctx.dmem.addr;
        ret_d.dmem_mask  = i_ctx.dmem.mask;
        ret_d.dmem_ren   = i_ctx.dmem.ren;
        ret_d.dmem_wen   = i_ctx.dmem.wen;
        ret_d.dmem_rdata = i_dmem_rdata;
        ret_d.dmem_wdata = i_ctx.dmem.wdata;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_q <= 1'b0;
            ren_q <= 1'b0;
            wen_q <= 1'b0;
        end else begin
            vld_q <= ret_d.valid;
            ren_q <= ret_d.dmem_ren;
            wen_q <= ret_d.dmem_wen;
        end
    end

    always_ff @(posedge i_clk) begin
        ret_q <= ret_d;
    end

    always_comb begin
        o_retire          = ret_q;
        o_retire.valid    = vld_q;
        o_retire.dmem_ren = ren_q;
        o_retire.dmem_wen = wen_q;
    end

    // Half loads arrive on an even byte offset
    a_half_even: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ctx.valid && i_ctx.is_load &&
         (i_ctx.funct3 == rv_isa_pkg::F3_HALF || i_ctx.funct3 == rv_isa_pkg::F3_HALF_U))
        |-> !i_ctx.offset[0])
        else $error("half-word load at odd offset");

endmodule

`default_nettype wire

// File: lsu_top.sv
`default_nettype none

module lsu_top (
    // Core clock
    input  logic                     i_clk,
    // Async reset, active low
    input  logic                     i_rst_n,
    // Load/store request, one per cycle, never refused
    input  lsu_bus_pkg::mem_req_t    i_req,
    // Data memory port, writes land on the next edge
    output lsu_bus_pkg::dmem_req_t   o_dmem,
    // Read data, one cycle after the edge that saw ren
    input  rv_isa_pkg::xword_t       i_dmem_rdata,
    // Retire record, two cycles after the request
    output lsu_bus_pkg::retire_rec_t o_retire
);

    ////////////////////
    // Stage links
    ////////////////////

    // MEM stage context into the MEM/WB register
    lsu_bus_pkg::mem_ctx_t mem_ctx;

    // Context aligned with returning read data
    lsu_bus_pkg::mem_ctx_t wb_ctx;

    // EX/MEM register and dmem request
    mem_req_stage mem_req_stage_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (i_req),
        .o_dmem  (o_dmem),
        .o_ctx   (mem_ctx)
    );

    // MEM/WB register
    mem_wb_stage mem_wb_stage_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ctx   (mem_ctx),
        .o_ctx   (wb_ctx)
    );

    // Load extension and retire record
    load_align load_align_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_ctx        (wb_ctx),
        .i_dmem_rdata (i_dmem_rdata),
        .o_retire     (o_retire)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 10;

    // Free running clock, 8 ns period
    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Reset low for ten rising edges, released on a falling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_lsu_top.sv
`default_nettype none

module tb_lsu_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD_NS  = 8;
    localparam int MEM_WORDS  = 64;
    localparam int N_IDLE     = 20;
    localparam int N_STORE    = 7;
    localparam int N_LOAD     = 14;
    localparam int N_PINGPONG = 16;
    localparam int N_RANDOM   = 300;
    localparam int N_TOTAL    = N_IDLE + N_STORE + N_LOAD + N_PINGPONG + N_RANDOM;
    // One cycle per request, plus reset, drain and slack
    localparam int TIMEOUT_NS = (N_TOTAL + 10 + 50) * PERIOD_NS;

    // Expected dmem request and retire record of one issued request
    typedef struct packed {
        lsu_bus_pkg::dmem_req_t   dmem;
        lsu_bus_pkg::retire_rec_t ret;
    } expect_t;

    logic                     clk;
    logic                     rst_n;
    lsu_bus_pkg::mem_req_t    req;
    lsu_bus_pkg::dmem_req_t   dmem;
    rv_isa_pkg::xword_t       dmem_rdata = '0;
    lsu_bus_pkg::retire_rec_t retire;

    // DUT memory and its shadow in the reference
    rv_isa_pkg::xword_t mem    [MEM_WORDS];
    rv_isa_pkg::xword_t shadow [MEM_WORDS];

    expect_t     exp_q [$];
    int          n_issued  = 0;
    int          n_checked = 0;
    logic [31:0] rng_state;

    // Compare pipe, one slot per edge since the request was sampled
    expect_t p1;
    expect_t p2;
    expect_t p3;
    logic    v1 = 1'b0;
    logic    v2 = 1'b0;
    logic    v3 = 1'b0;

    tb_clock_gen clock_gen_inst (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    lsu_top lsu_top_inst (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_req        (req),
        .o_dmem       (dmem),
        .i_dmem_rdata (dmem_rdata),
        .o_retire     (retire)
    );

    ////////////////////
    // Data memory model
    ////////////////////

    // Registered read first, then masked byte writes
    always @(posedge clk) begin
        dmem_rdata <= dmem.ren ? mem[dmem.addr[7:2]] : '0;
        if (dmem.wen) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem.mask[i]) begin
                    mem[dmem.addr[7:2]][8*i +: 8] = dmem.wdata[8*i +: 8];
                end
            end
        end
    end

    function automatic rv_isa_pkg::xword_t fill_word(input int idx);
        return (idx + 1) * 32'h9E37_79B1;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    function automatic rv_isa_pkg::lane_mask_t lane_mask(input rv_isa_pkg::funct3_t f3,
                                                          input logic [1:0] off);
        case (f3)
            rv_isa_pkg::F3_BYTE, rv_isa_pkg::F3_BYTE_U: return 4'b0001 << off;
            rv_isa_pkg::F3_HALF, rv_isa_pkg::F3_HALF_U: return off[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic rv_isa_pkg::xword_t place_wdata(input rv_isa_pkg::funct3_t f3,
                                                        input logic [1:0] off,
                                                        input rv_isa_pkg::xword_t wdata);
        case (f3)
            rv_isa_pkg::F3_BYTE, rv_isa_pkg::F3_BYTE_U: return wdata << (8 * off);
            rv_isa_pkg::F3_HALF, rv_isa_pkg::F3_HALF_U: return wdata << (16 * off[1]);
            default: return wdata;
        endcase
    endfunction

    function automatic rv_isa_pkg::xword_t extend_load(input rv_isa_pkg::funct3_t f3,
                                                        input logic [1:0] off,
                                                        input rv_isa_pkg::xword_t word);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        // Bit 0 plays no part in half selection
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            rv_isa_pkg::F3_BYTE:   return {{24{b[7]}}, b};
            rv_isa_pkg::F3_BYTE_U: return {24'h0, b};
            rv_isa_pkg::F3_HALF:   return {{16{h[15]}}, h};
            rv_isa_pkg::F3_HALF_U: return {16'h0, h};
            default:               return word;
        endcase
    endfunction

    function automatic expect_t expected_access(input lsu_bus_pkg::mem_req_t r);
        expect_t    e;
        logic [1:0] off;
        off              = r.addr[1:0];
        e.dmem.addr      = {r.addr[31:2], 2'b00};
        e.dmem.ren       = r.valid & r.is_load;
        e.dmem.wen       = r.valid & r.is_store;
        e.dmem.mask      = lane_mask(r.funct3, off);
        e.dmem.wdata     = place_wdata(r.funct3, off, r.wdata);
        e.ret.valid      = r.valid;
        e.ret.rd_waddr   = e.dmem.ren ? r.rd : '0;
        // Memory returns zero when not read
        e.ret.dmem_rdata = e.dmem.ren ? shadow[r.addr[7:2]] : '0;
        e.ret.rd_wdata   = extend_load(r.funct3, off, e.ret.dmem_rdata);
        e.ret.dmem_addr  = e.dmem.addr;
        e.ret.dmem_mask  = e.dmem.mask;
        e.ret.dmem_ren   = e.dmem.ren;
        e.ret.dmem_wen   = e.dmem.wen;
        e.ret.dmem_wdata = e.dmem.wdata;
        return e;
    endfunction

    task automatic commit_store(input lsu_bus_pkg::dmem_req_t d);
        for (int i = 0; i < 4; i++) begin
            if (d.wen && d.mask[i]) begin
                shadow[d.addr[7:2]][8*i +: 8] = d.wdata[8*i +: 8];
            end
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic lsu_bus_pkg::mem_req_t make_req(input logic ld,
                                                      input rv_isa_pkg::funct3_t f3,
                                                      input rv_isa_pkg::xword_t addr,
                                                      input rv_isa_pkg::xword_t wdata,
                                                      input rv_isa_pkg::reg_addr_t rd);
        lsu_bus_pkg::mem_req_t r;
        r.valid    = 1'b1;
        r.is_load  = ld;
        r.is_store = !ld;
        r.funct3   = f3;
        r.addr     = addr;
        r.wdata    = wdata;
        r.rd       = rd;
        return r;
    endfunction

    // About one bubble in five, bubbles keep a random payload
    function automatic lsu_bus_pkg::mem_req_t random_req();
        lsu_bus_pkg::mem_req_t r;
        logic [31:0]           a;
        logic [31:0]           b;
        a          = next_rand();
        b          = next_rand();
        r.valid    = a[31:28] > 4'd2;
        r.is_load  = a[27];
        r.is_store = !a[27];
        if (a[27] && a[26]) begin
            r.funct3 = {1'b1, 2'(a[25:24] % 2)};
        end else begin
            r.funct3 = 3'(a[25:24] % 3);
        end
        r.addr = {24'h0, b[31:24]};
        // Halves on even offsets, words aligned
        if (r.funct3[1:0] == 2'b01) begin
            r.addr[0] = 1'b0;
        end else if (r.funct3[1:0] == 2'b10) begin
            r.addr[1:0] = 2'b00;
        end
        r.wdata = next_rand();
        r.rd    = b[15:11];
        return r;
    endfunction

    // Drive on the falling edge and queue what the DUT should produce
    task automatic issue(input lsu_bus_pkg::mem_req_t r);
        expect_t e;
        @(negedge clk);
        req = r;
        e   = expected_access(r);
        commit_store(e.dmem);
        exp_q.push_back(e);
        n_issued++;
    endtask

    ////////////////////
    // Checking
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h at %0t ns", name, got, exp, $time);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Pre-edge values are the ones held through the last cycle
    always @(posedge clk) begin
        if (v1) begin
            check_value("o_dmem.addr", dmem.addr, p1.dmem.addr);
            check_value("o_dmem.ren", dmem.ren, p1.dmem.ren);
            check_value("o_dmem.wen", dmem.wen, p1.dmem.wen);
            check_value("o_dmem.mask", dmem.mask, p1.dmem.mask);
            check_value("o_dmem.wdata", dmem.wdata, p1.dmem.wdata);
        end
        if (v3) begin
            check_value("o_retire.valid", retire.valid, p3.ret.valid);
            check_value("o_retire.rd_waddr", retire.rd_waddr, p3.ret.rd_waddr);
            check_value("o_retire.rd_wdata", retire.rd_wdata, p3.ret.rd_wdata);
            check_value("o_retire.dmem_addr", retire.dmem_addr, p3.ret.dmem_addr);
            check_value("o_retire.dmem_mask", retire.dmem_mask, p3.ret.dmem_mask);
            check_value("o_retire.dmem_ren", retire.dmem_ren, p3.ret.dmem_ren);
            check_value("o_retire.dmem_wen", retire.dmem_wen, p3.ret.dmem_wen);
            check_value("o_retire.dmem_rdata", retire.dmem_rdata, p3.ret.dmem_rdata);
            check_value("o_retire.dmem_wdata", retire.dmem_wdata, p3.ret.dmem_wdata);
            n_checked++;
        end
        p3 = p2;
        v3 = v2;
        p2 = p1;
        v2 = v1;
        if (exp_q.size() > 0) begin
            p1 = exp_q.pop_front();
            v1 = 1'b1;
        end else begin
            v1 = 1'b0;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        req       = '0;
        rng_state = 32'd12;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = fill_word(i);
        end

        // Quiet outputs while reset is held
        repeat (3) @(negedge clk);
        check_value("o_dmem.ren", dmem.ren, 0);
        check_value("o_dmem.wen", dmem.wen, 0);
        check_value("o_retire.valid", retire.valid, 0);
        wait (rst_n);

        // Idle after reset
        repeat (N_IDLE) issue('0);

        // Stores of each width at each legal offset
        for (int off = 0; off < 4; off++) begin
            issue(make_req(1'b0, rv_isa_pkg::F3_BYTE, 32'h40 + off, 32'h1234_56A0 + off, 5'd0));
        end
        issue(make_req(1'b0, rv_isa_pkg::F3_HALF, 32'h44, 32'hDEAD_BEEF, 5'd0));
        issue(make_req(1'b0, rv_isa_pkg::F3_HALF, 32'h46, 32'h0BAD_F00D, 5'd0));
        issue(make_req(1'b0, rv_isa_pkg::F3_WORD, 32'h48, 32'hCAFE_0123, 5'd0));

        // Word store, then every load width and offset over it
        issue(make_req(1'b0, rv_isa_pkg::F3_WORD, 32'h80, 32'hF012_7E85, 5'd0));
        for (int off = 0; off < 4; off++) begin
            issue(make_req(1'b1, rv_isa_pkg::F3_BYTE, 32'h80 + off, '0, 5'(1 + off)));
            issue(make_req(1'b1, rv_isa_pkg::F3_BYTE_U, 32'h80 + off, '0, 5'(5 + off)));
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(make_req(1'b1, rv_isa_pkg::F3_HALF, 32'h80 + off, '0, 5'(9 + off)));
            issue(make_req(1'b1, rv_isa_pkg::F3_HALF_U, 32'h80 + off, '0, 5'(10 + off)));
        end
        issue(make_req(1'b1, rv_isa_pkg::F3_WORD, 32'h80, '0, 5'd31));

        // Back to back store and load on one word, three in flight
        for (int i = 0; i < N_PINGPONG / 2; i++) begin
            issue(make_req(1'b0, rv_isa_pkg::F3_BYTE, 32'hC4 + (i % 4), 32'h30 + i, 5'd0));
            issue(make_req(1'b1, rv_isa_pkg::F3_WORD, 32'hC4, '0, 5'(i + 1)));
        end

        // Random mix with bubbles
        repeat (N_RANDOM) issue(random_req());

        // Drain without queueing more records
        @(negedge clk);
        req = '0;
        repeat (5) @(negedge clk);

        if (n_checked == n_issued && exp_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Retire records missing: %0d issued, %0d checked", n_issued, n_checked);
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
rv_isa_pkg.sv
lsu_bus_pkg.sv
mem_req_stage.sv
mem_wb_stage.sv
load_align.sv
lsu_top.sv
tb_clock_gen.sv
tb_lsu_top.sv
